/* lc3Lite.f */
+incdir+logic
logic/lc3Pkg.sv
logic/aluUnit.sv
logic/regFile.sv
logic/dataPath.sv
logic/controlUnit.sv
logic/memBridge.sv
logic/lc3Core.sv
verif/lc3Tb.sv

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module aluUnit (
	input lc3Pkg::aluOpT aluK,
	input logic [`WORD_W-1:0] a,
	input logic [`WORD_W-1:0] b,
	input logic [`WORD_W-1:0] ir,
	output logic [`WORD_W-1:0] result
);
	import lc3Pkg::*;

	logic [`WORD_W-1:0] imm5;
	logic [`WORD_W-1:0] operandB;

	assign imm5 = {{(`WORD_W-5){ir[4]}}, ir[4:0]};

	// immediate form when IR[5] is set
	assign operandB = ir[5] ? imm5 : b;

	always_comb
	begin
		case (aluK)
			ALU_ADD: result = a + operandB;
			ALU_AND: result = a & operandB;
			ALU_NOT: result = ~a;
			default: result = a;
		endcase
	end

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module controlUnit (
	input logic Clk,
	input logic reset,
	input logic run,
	input logic continueIn,
	input logic ben,
	input logic memDone,
	input logic [`WORD_W-1:0] ir,
	output logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
	output logic gatePc, gateMdr, gateAlu, gateMarMux,
	output logic [1:0] pcMux,
	output logic [1:0] addr2Mux,
	output logic addr1Mux, drMux, sr1Mux, mioEn,
	output lc3Pkg::aluOpT aluK,
	output logic memReq,
	output logic memWrite,
	output logic paused
);
	import lc3Pkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	opcodeT opcode;

	assign opcode = opcodeT'(ir[15:12]);

	always_ff @(posedge Clk)
	begin
		if (reset)
			state <= S_HALT;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			S_HALT:
				if (run)
					nextState = S_FETCH1;
			S_FETCH1: nextState = S_FETCH2;
			S_FETCH2:
				if (memDone)
					nextState = S_FETCH3;
			S_FETCH3: nextState = S_DECODE;
			S_DECODE:
				case (opcode)
					OP_ADD, OP_AND, OP_NOT: nextState = S_ALU;
					OP_BR: nextState = S_BR;
					OP_JMP: nextState = S_JMP;
					OP_LD: nextState = S_LDADDR;
					OP_ST: nextState = S_STADDR;
					OP_PAUSE: nextState = S_PAUSE1;
					default: nextState = S_FETCH1; // unsupported opcode is skipped
				endcase
			S_BR: nextState = ben ? S_BRTAKE : S_FETCH1;
			S_LDADDR: nextState = S_LDMEM;
			S_LDMEM:
				if (memDone)
					nextState = S_LDREG;
			S_STADDR: nextState = S_STDATA;
			S_STDATA: nextState = S_STMEM;
			S_STMEM:
				if (memDone)
					nextState = S_FETCH1;
			S_PAUSE1:
				if (continueIn)
					nextState = S_PAUSE2;
			S_PAUSE2:
				if (!continueIn)
					nextState = S_FETCH1;
			default: nextState = S_FETCH1; // ALU, BRTAKE, JMP
		endcase
	end

	// pcMux 00 pc+1, 01 bus, 10 adder; addr2Mux 10 is the 9-bit offset
	always_comb
	begin
		{ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed} = '0;
		{gatePc, gateMdr, gateAlu, gateMarMux} = '0;
		pcMux = 2'b00;
		addr2Mux = 2'b00;
		addr1Mux = 1'b0;
		drMux = 1'b0; // R7 destination only matters for JSR
		sr1Mux = 1'b0;
		mioEn = 1'b0;
		aluK = ALU_PASSA;
		memReq = 1'b0;
		memWrite = 1'b0;
		paused = 1'b0;
		case (state)
			S_FETCH1:
			begin
				gatePc = 1'b1;
				ldMar = 1'b1;
				ldPc = 1'b1;
			end
			S_FETCH2, S_LDMEM:
			begin
				memReq = 1'b1;
				mioEn = 1'b1;
				ldMdr = memDone;
			end
			S_FETCH3:
			begin
				gateMdr = 1'b1;
				ldIr = 1'b1;
			end
			S_DECODE:
			begin
				ldBen = 1'b1;
				ldLed = (opcode == OP_PAUSE); // code is up before paused rises
			end
			S_ALU:
			begin
				gateAlu = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
				case (opcode)
					OP_ADD: aluK = ALU_ADD;
					OP_AND: aluK = ALU_AND;
					default: aluK = ALU_NOT;
				endcase
			end
			S_BRTAKE:
			begin
				ldPc = 1'b1;
				pcMux = 2'b10;
				addr2Mux = 2'b10;
			end
			S_JMP:
			begin
				ldPc = 1'b1;
				pcMux = 2'b10;
				addr1Mux = 1'b1; // base register plus zero
			end
			S_LDADDR, S_STADDR:
			begin
				gateMarMux = 1'b1;
				ldMar = 1'b1;
				addr2Mux = 2'b10;
			end
			S_LDREG:
			begin
				gateMdr = 1'b1;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			S_STDATA:
			begin
				sr1Mux = 1'b1; // source register sits in IR[11:9] for ST
				gateAlu = 1'b1;
				ldMdr = 1'b1;
			end
			S_STMEM:
			begin
				memReq = 1'b1;
				memWrite = 1'b1;
			end
			S_PAUSE1: paused = 1'b1;
			default: ;
		endcase
	end

	// encodings past S_PAUSE2 are never entered
	stateLegal: assert property (@(posedge Clk) disable iff (reset) state <= S_PAUSE2);

	reqHeld: assert property (@(posedge Clk) disable iff (reset)
		$fell(memReq) |-> $past(memDone));

endmodule

/* logic/dataPath.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module dataPath (
	input logic Clk,
	input logic reset,
	input logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
	input logic gatePc, gateMdr, gateAlu, gateMarMux,
	input logic [1:0] pcMux,
	input logic [1:0] addr2Mux,
	input logic addr1Mux, drMux, sr1Mux, mioEn,
	input lc3Pkg::aluOpT aluK,
	input logic [`WORD_W-1:0] memData,
	output logic [`WORD_W-1:0] ir,
	output logic [`WORD_W-1:0] mar,
	output logic [`WORD_W-1:0] mdr,
	output logic ben,
	output logic [11:0] ledOut
);
	logic [`WORD_W-1:0] bus, pc, pcPlus1, pcNext;
	logic [`WORD_W-1:0] sr1Out, sr2Out, aluOut;
	logic [`WORD_W-1:0] addr1, addr2, addrSum;
	logic [2:0] dr, sr1;
	logic [2:0] nzp;

	assign dr = drMux ? 3'b111 : ir[11:9];
	assign sr1 = sr1Mux ? ir[11:9] : ir[8:6];

	regFile regFile_i (
		.Clk(Clk),
		.reset(reset),
		.ldReg(ldReg),
		.dr(dr),
		.sr1(sr1),
		.sr2(ir[2:0]),
		.busIn(bus),
		.sr1Out(sr1Out),
		.sr2Out(sr2Out)
	);

	aluUnit aluUnit_i (
		.aluK(aluK),
		.a(sr1Out),
		.b(sr2Out),
		.ir(ir),
		.result(aluOut)
	);

	// one source on the bus at a time, MDR wins
	always_comb
	begin
		if (gateMdr)
			bus = mdr;
		else if (gateAlu)
			bus = aluOut;
		else if (gatePc)
			bus = pc;
		else if (gateMarMux)
			bus = addrSum;
		else
			bus = '0;
	end

	assign addr1 = addr1Mux ? sr1Out : pc;

	always_comb
	begin
		case (addr2Mux)
			2'b00: addr2 = '0;
			2'b01: addr2 = {{(`WORD_W-6){ir[5]}}, ir[5:0]};
			2'b10: addr2 = {{(`WORD_W-9){ir[8]}}, ir[8:0]};
			default: addr2 = {{(`WORD_W-11){ir[10]}}, ir[10:0]};
		endcase
	end

	assign addrSum = addr1 + addr2;
	assign pcPlus1 = pc + 1'b1;

	always_comb
	begin
		case (pcMux)
			2'b00: pcNext = pcPlus1;
			2'b01: pcNext = bus;
			default: pcNext = addrSum;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			pc <= `RESET_PC;
		else if (ldPc)
			pc <= pcNext;
	end

	always_ff @(posedge Clk)
	begin
		if (ldMar)
			mar <= bus;
		if (ldIr)
			ir <= bus;
		if (ldMdr)
			mdr <= mioEn ? memData : bus; // memory read or store data
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			nzp <= 3'b000;
			ben <= 1'b0;
			ledOut <= '0;
		end
		else
		begin
			if (ldCc)
				nzp <= {bus[`WORD_W-1], bus == '0, !bus[`WORD_W-1] && bus != '0};
			if (ldBen)
				ben <= |(ir[11:9] & nzp);
			if (ldLed)
				ledOut <= ir[11:0];
		end
	end

endmodule

/* logic/lc3Core.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module lc3Core (
	input logic Clk,
	input logic reset,
	input logic run,
	input logic continueIn,
	input logic [`WORD_W-1:0] prdata,
	input logic pready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [`WORD_W-1:0] paddr,
	output logic [`WORD_W-1:0] pwdata,
	output logic [11:0] ledOut,
	output logic paused
);
	import lc3Pkg::*;

	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	logic gatePc, gateMdr, gateAlu, gateMarMux;
	logic [1:0] pcMux;
	logic [1:0] addr2Mux;
	logic addr1Mux, drMux, sr1Mux, mioEn;
	aluOpT aluK;
	logic [`WORD_W-1:0] ir, mar, mdr, memData;
	logic ben;
	logic memReq, memWrite, memDone;

	// control and datapath share port names one for one
	controlUnit controlUnit_i (.*);

	dataPath dataPath_i (.*);

	memBridge memBridge_i (
		.Clk(Clk),
		.reset(reset),
		.memReq(memReq),
		.memWrite(memWrite),
		.mar(mar),
		.mdr(mdr),
		.prdata(prdata),
		.pready(pready),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.memData(memData),
		.memDone(memDone)
	);

endmodule

/* logic/lc3Pkg.sv */
package lc3Pkg;

	// LC-3 opcode field, IR[15:12]
	typedef enum logic [3:0] {
		OP_BR    = 4'b0000,
		OP_ADD   = 4'b0001,
		OP_LD    = 4'b0010,
		OP_ST    = 4'b0011,
		OP_AND   = 4'b0101,
		OP_NOT   = 4'b1001,
		OP_JMP   = 4'b1100,
		OP_PAUSE = 4'b1101
	} opcodeT;

	typedef enum logic [4:0] {
		S_HALT, S_FETCH1, S_FETCH2, S_FETCH3, S_DECODE,
		S_ALU, S_BR, S_BRTAKE, S_JMP,
		S_LDADDR, S_LDMEM, S_LDREG,
		S_STADDR, S_STDATA, S_STMEM,
		S_PAUSE1, S_PAUSE2
	} ctrlStateT;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_AND,
		ALU_NOT,
		ALU_PASSA // operand a straight through, used for ST data
	} aluOpT;

endpackage

/* logic/lc3_consts.svh */
`ifndef LC3_CONSTS_SVH
`define LC3_CONSTS_SVH

// datapath and address width
`define WORD_W 16

// general purpose registers R0..R7
`define REG_CNT 8

`define RESET_PC 16'h0000 // first fetch address out of reset

// clock cycles allowed for a program to reach PAUSE before it counts as hung
`define WATCHDOG_LIMIT 4000

`endif

/* logic/memBridge.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module memBridge (
	input logic Clk,
	input logic reset,
	input logic memReq,
	input logic memWrite,
	input logic [`WORD_W-1:0] mar,
	input logic [`WORD_W-1:0] mdr,
	input logic [`WORD_W-1:0] prdata,
	input logic pready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [`WORD_W-1:0] paddr,
	output logic [`WORD_W-1:0] pwdata,
	output logic [`WORD_W-1:0] memData,
	output logic memDone
);
	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbStateT;

	apbStateT state;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			pwrite <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (memReq)
					begin
						state <= SETUP;
						pwrite <= memWrite;
					end
				SETUP: state <= ACCESS;
				default:
					if (pready)
						state <= IDLE; // wait states hold ACCESS
			endcase
		end
	end

	// address and write data captured as SETUP starts
	always_ff @(posedge Clk)
	begin
		if (state == IDLE && memReq)
		begin
			paddr <= mar;
			pwdata <= mdr;
		end
	end

	assign psel = (state != IDLE);
	assign penable = (state == ACCESS);
	assign memDone = penable && pready;
	assign memData = prdata; // sampled into MDR on the memDone edge

	// every ACCESS cycle follows a cycle with psel up
	enableInSel: assert property (@(posedge Clk) disable iff (reset) penable |-> $past(psel));

	addrHeld: assert property (@(posedge Clk) disable iff (reset)
		penable && !pready |=> $stable(paddr) && $stable(pwrite));

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module regFile (
	input logic Clk,
	input logic reset,
	input logic ldReg,
	input logic [2:0] dr,
	input logic [2:0] sr1,
	input logic [2:0] sr2,
	input logic [`WORD_W-1:0] busIn,
	output logic [`WORD_W-1:0] sr1Out,
	output logic [`WORD_W-1:0] sr2Out
);
	logic [`WORD_W-1:0] regs [`REG_CNT];

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end
		else if (ldReg)
			regs[dr] <= busIn;
	end

	// reads see the old value during a write cycle
	assign sr1Out = regs[sr1];
	assign sr2Out = regs[sr2];

endmodule

/* run.sh */
#!/bin/sh
# builds the lc3Lite testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lc3Tb -f lc3Lite.f -o lc3Sim \
	&& ./obj_dir/lc3Sim | tee /dev/stderr | grep -q "^test passed$" \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }

/* verif/lc3Tb.sv */
`timescale 1ns/1ps
`include "lc3_consts.svh"

module lc3Tb;
	localparam int numTests = 4;

	logic Clk, reset, run, continueIn, pready;
	logic [`WORD_W-1:0] prdata;
	logic psel, penable, pwrite, paused;
	logic [`WORD_W-1:0] paddr, pwdata;
	logic [11:0] ledOut;

	// programs padded with BR never (0x0000)
	string testName [numTests] = '{"alu", "load", "branch", "jump"};
	logic [15:0] progTable [numTests][12] = '{
		'{16'h1225, 16'h147D, 16'h1642, 16'h58E6, 16'h9B3F, 16'h5D43,
			16'h1D85, 16'h3C28, 16'hD123, 16'h0000, 16'h0000, 16'h0000},
		'{16'h243F, 16'h344E, 16'hD456, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h123F, 16'h0401, 16'h322D, 16'h0801, 16'h322C, 16'hD789,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h162A, 16'hD0A1, 16'hC0C0, 16'h3600, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h3655, 16'hDB2C}
	};
	logic [15:0] storeAddrTab [numTests] = '{16'h0030, 16'h0050, 16'h0030, 16'h0060};
	// 0xBF40 is fill of 0x40
	logic [15:0] storeValTab [numTests] = '{16'hFFFA, 16'hBF40, 16'hFFFF, 16'h000A};
	int pauseCnt [numTests] = '{1, 1, 1, 2};
	logic [11:0] ledFirst [numTests] = '{12'h123, 12'h456, 12'h789, 12'h0A1};
	logic [11:0] ledLast [numTests] = '{12'h123, 12'h456, 12'h789, 12'hB2C};
	logic [15:0] jmpFrom [numTests] = '{16'h0000, 16'h0000, 16'h0000, 16'h0002};
	logic [15:0] jmpTo [numTests] = '{16'h0000, 16'h0000, 16'h0000, 16'h000A};

	logic [15:0] mem [256];
	logic [15:0] readAddrQ [$];
	logic [15:0] writeAddrQ [$];
	logic [15:0] writeDataQ [$];
	logic [31:0] lfsr = 32'h6142b4d6;
	logic [1:0] waitLeft;
	logic [15:0] setupAddr;
	logic setupWrite;
	logic prevPsel = 1'b0;
	logic prevPenable = 1'b0;
	int transferCnt = 0;
	int errCount = 0;

	lc3Core lc3Core_i (
		.Clk(Clk),
		.reset(reset),
		.run(run),
		.continueIn(continueIn),
		.prdata(prdata),
		.pready(pready),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.ledOut(ledOut),
		.paused(paused)
	);

	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] fillWord(input logic [7:0] a);
		return {~a, a};
	endfunction

	task automatic compareValue(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errCount++;
		end
	endtask

	// APB slave with 0..3 wait states, checks the handshake as it goes
	always @(negedge Clk)
	begin
		if (penable && !prevPenable)
			compareValue("psel", {15'b0, prevPsel}, 16'd1);
		if (prevPsel && !prevPenable)
			compareValue("penable", {15'b0, penable}, 16'd1);
		if (psel && !penable)
		begin
			lfsr = lfsrNext(lfsr);
			waitLeft[0] = lfsr[0];
			lfsr = lfsrNext(lfsr);
			waitLeft[1] = lfsr[0];
			setupAddr = paddr;
			setupWrite = pwrite;
			transferCnt++;
			pready = 1'b0;
		end
		else if (penable)
		begin
			compareValue("paddr", paddr, setupAddr);
			compareValue("pwrite", {15'b0, pwrite}, {15'b0, setupWrite});
			if (waitLeft == 2'd0)
			begin
				pready = 1'b1;
				if (pwrite)
				begin
					mem[paddr[7:0]] = pwdata;
					writeAddrQ.push_back(paddr);
					writeDataQ.push_back(pwdata);
				end
				else
				begin
					prdata = mem[paddr[7:0]];
					readAddrQ.push_back(paddr);
				end
			end
			else
			begin
				waitLeft = waitLeft - 2'd1;
				pready = 1'b0;
			end
		end
		else
			pready = 1'b0;
		prevPsel = psel;
		prevPenable = penable;
	end

	task automatic startProgram(input int t);
		@(negedge Clk);
		reset = 1'b1;
		run = 1'b0;
		continueIn = 1'b0;
		for (int a = 0; a < 256; a++)
			mem[a] = fillWord(8'(a));
		for (int i = 0; i < 12; i++)
			mem[i] = progTable[t][i];
		repeat (4) @(negedge Clk);
		reset = 1'b0;
		readAddrQ.delete();
		writeAddrQ.delete();
		writeDataQ.delete();
		transferCnt = 0;
		repeat (3) @(negedge Clk); // core must stay off the bus until run
		compareValue("psel count before run", 16'(transferCnt), 16'd0);
		run = 1'b1;
		@(negedge Clk);
		run = 1'b0;
	endtask

	task automatic waitPausedLevel(input logic level, output bit ok);
		int cycles;
		cycles = 0;
		while (paused !== level && cycles < `WATCHDOG_LIMIT)
		begin
			@(negedge Clk);
			cycles++;
		end
		ok = (paused === level);
	endtask

	task automatic checkResults(input int t);
		int idx;
		idx = -1;
		compareValue("write count", 16'(writeAddrQ.size()), 16'd1);
		if (writeAddrQ.size() > 0)
		begin
			compareValue("paddr of store", writeAddrQ[0], storeAddrTab[t]);
			compareValue("pwdata", writeDataQ[0], storeValTab[t]);
		end
		if (jmpTo[t] != 16'h0000)
		begin
			for (int i = 0; i < readAddrQ.size(); i++)
				if (readAddrQ[i] == jmpFrom[t] && idx < 0)
					idx = i;
			if (idx < 0 || idx + 1 >= readAddrQ.size())
			begin
				$display("%s: no fetch seen after the JMP instruction", testName[t]);
				errCount++;
			end
			else
				compareValue("paddr after JMP", readAddrQ[idx + 1], jmpTo[t]);
		end
	endtask

	initial
	begin
		int errBefore;
		int testsRun;
		int cleanCnt;
		bit ok;
		string failWhy;
		reset = 1'b1;
		run = 1'b0;
		continueIn = 1'b0;
		prdata = '0;
		pready = 1'b0;
		testsRun = 0;
		cleanCnt = 0;
		ok = 1'b1;
		for (int t = 0; t < numTests && ok; t++)
		begin
			errBefore = errCount;
			failWhy = "core never paused";
			startProgram(t);
			waitPausedLevel(1'b1, ok);
			if (ok)
				compareValue("ledOut", {4'h0, ledOut}, {4'h0, ledFirst[t]});
			if (ok && pauseCnt[t] == 2)
			begin
				continueIn = 1'b1;
				waitPausedLevel(1'b0, ok);
				continueIn = 1'b0;
				if (!ok)
					failWhy = "core stayed paused after continueIn";
				if (ok)
					waitPausedLevel(1'b1, ok);
				if (ok)
					compareValue("ledOut", {4'h0, ledOut}, {4'h0, ledLast[t]});
			end
			if (!ok)
			begin
				$display("%s: %s within %0d cycles", testName[t], failWhy,
					`WATCHDOG_LIMIT);
				errCount++;
			end
			else
				checkResults(t);
			testsRun++;
			if (errCount == errBefore)
			begin
				cleanCnt++;
				$display("%s: ok", testName[t]);
			end
			else
				$display("%s: %0d mismatches", testName[t], errCount - errBefore);
		end
		$display("%0d of %0d programs clean, %0d errors", cleanCnt, testsRun, errCount);
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
